//--- build.f
logic/rv_core_pkg.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_core.sv
testbench/rv_core_chk.sv
testbench/tb_rv_core.sv

//--- logic/rv_alu.sv
// combinational integer ALU used by the execute stage
`timescale 1ns/1ps
`default_nettype none

module rv_alu #(
    parameter int XLEN = 64
) (
    input  wire rv_core_pkg::alu_op_e op_i,
    input  wire logic [XLEN-1:0]      a_i,
    input  wire logic [XLEN-1:0]      b_i,
    output logic [XLEN-1:0]           result_o
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0] shamt;
    logic           lt_s;
    logic           lt_u;

    // shifts use only the low bits of b
    assign shamt = b_i[SHW-1:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            rv_core_pkg::alu_add:    result_o = a_i + b_i;
            rv_core_pkg::alu_sub:    result_o = a_i - b_i;
            rv_core_pkg::alu_sll:    result_o = a_i << shamt;
            rv_core_pkg::alu_slt:    result_o = XLEN'(lt_s);
            rv_core_pkg::alu_sltu:   result_o = XLEN'(lt_u);
            rv_core_pkg::alu_xor:    result_o = a_i ^ b_i;
            rv_core_pkg::alu_srl:    result_o = a_i >> shamt;
            rv_core_pkg::alu_sra:    result_o = $signed(a_i) >>> shamt;
            rv_core_pkg::alu_or:     result_o = a_i | b_i;
            rv_core_pkg::alu_and:    result_o = a_i & b_i;
            rv_core_pkg::alu_pass_b: result_o = b_i;
            default:                 result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_core.sv
// top level of the two-stage integer pipeline; instantiate with the desired XLEN
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter int XLEN = 64
) (
    input  wire logic                   c_clk,
    input  wire logic                   c_rst_n,
    input  wire logic                   in_valid_i,
    input  wire rv_core_pkg::instr_t    in_instr_i,
    output logic                        in_ready_o,
    output logic                        wb_valid_o,
    output rv_core_pkg::reg_addr_t      wb_rd_o,
    output logic [XLEN-1:0]             wb_data_o,
    input  wire logic                   wb_ready_i
);

    logic                   dec_valid;
    logic                   dec_ready;
    rv_core_pkg::dec_t      dec;
    rv_core_pkg::reg_addr_t rs1;
    rv_core_pkg::reg_addr_t rs2;
    logic [XLEN-1:0]        rs1_data;
    logic [XLEN-1:0]        rs2_data;
    logic                   we;

    rv_decode decode_i (
        .c_clk       (c_clk),
        .c_rst_n     (c_rst_n),
        .in_valid_i  (in_valid_i),
        .in_instr_i  (in_instr_i),
        .in_ready_o  (in_ready_o),
        .dec_valid_o (dec_valid),
        .dec_o       (dec),
        .dec_ready_i (dec_ready)
    );

    rv_execute #(
        .XLEN        (XLEN)
    ) execute_i (
        .c_clk       (c_clk),
        .c_rst_n     (c_rst_n),
        .dec_valid_i (dec_valid),
        .dec_i       (dec),
        .dec_ready_o (dec_ready),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .we_o        (we),
        .wb_valid_o  (wb_valid_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o),
        .wb_ready_i  (wb_ready_i)
    );

    // write port fed straight from the result register
    rv_regfile #(
        .XLEN        (XLEN)
    ) regfile_i (
        .c_clk       (c_clk),
        .c_rst_n     (c_rst_n),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .we_i        (we),
        .rd_i        (wb_rd_o),
        .rd_data_i   (wb_data_o)
    );

endmodule

`default_nettype wire

//--- logic/rv_core_pkg.sv
// shared types for the integer pipeline; modules refer to members as rv_core_pkg::name
`default_nettype none

package rv_core_pkg;

    localparam int REG_COUNT = 32;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes handled by decode
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op_reg = 7'b0110011,
        op_lui = 7'b0110111
    } opcode_e;

    // encoding follows funct3 order with sub and sra placed after
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sll    = 4'd1,
        alu_slt    = 4'd2,
        alu_sltu   = 4'd3,
        alu_xor    = 4'd4,
        alu_srl    = 4'd5,
        alu_or     = 4'd6,
        alu_and    = 4'd7,
        alu_sub    = 4'd8,
        alu_sra    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    // one decoded instruction of 52 bits
    typedef struct packed {
        alu_op_e     alu_op;
        logic        use_imm;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        logic [31:0] imm;
    } dec_t;

endpackage

`default_nettype wire

//--- logic/rv_decode.sv
// decode stage that takes instruction words from the input stream and registers decoded records
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire logic                c_clk,
    input  wire logic                c_rst_n,
    input  wire logic                in_valid_i,
    input  wire rv_core_pkg::instr_t in_instr_i,
    output logic                     in_ready_o,
    output logic                     dec_valid_o,
    output rv_core_pkg::dec_t        dec_o,
    input  wire logic                dec_ready_i
);

    rv_core_pkg::opcode_e opcode;
    logic [2:0]           funct3;
    logic                 f7_b30;
    logic [31:0]          imm_mux;
    logic                 known;
    logic                 accept;
    rv_core_pkg::dec_t    dec_d;

    // funct3 to ALU op; bit 30 only selects sub on reg-reg
    function automatic rv_core_pkg::alu_op_e alu_map(input logic [2:0] f3,
                                                     input logic       b30,
                                                     input logic       is_reg);
        rv_core_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && b30) ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
            3'b001:  op = rv_core_pkg::alu_sll;
            3'b010:  op = rv_core_pkg::alu_slt;
            3'b011:  op = rv_core_pkg::alu_sltu;
            3'b100:  op = rv_core_pkg::alu_xor;
            3'b101:  op = b30 ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
            3'b110:  op = rv_core_pkg::alu_or;
            default: op = rv_core_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign opcode = rv_core_pkg::opcode_e'(in_instr_i[6:0]);
    assign funct3 = in_instr_i[14:12];
    assign f7_b30 = in_instr_i[30];

    // immediate format mux
    always_comb begin
        case (opcode)
            rv_core_pkg::op_imm: imm_mux = {{20{in_instr_i[31]}}, in_instr_i[31:20]};
            rv_core_pkg::op_lui: imm_mux = {in_instr_i[31:12], 12'b0};
            default:             imm_mux = '0;
        endcase
    end

    always_comb begin
        known         = 1'b1;
        dec_d.rs1     = in_instr_i[19:15];
        dec_d.rs2     = in_instr_i[24:20];
        dec_d.rd      = in_instr_i[11:7];
        dec_d.imm     = imm_mux;
        dec_d.use_imm = 1'b1;
        dec_d.alu_op  = rv_core_pkg::alu_add;
        case (opcode)
            rv_core_pkg::op_reg: begin
                dec_d.use_imm = 1'b0;
                dec_d.alu_op  = alu_map(funct3, f7_b30, 1'b1);
            end
            rv_core_pkg::op_imm: dec_d.alu_op = alu_map(funct3, f7_b30, 1'b0);
            rv_core_pkg::op_lui: dec_d.alu_op = rv_core_pkg::alu_pass_b;
            default:             known = 1'b0;
        endcase
    end

    // stage can take a word when empty or draining this cycle
    assign in_ready_o = !dec_valid_o || dec_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            dec_valid_o <= 1'b0;
        end else if (accept) begin
            // unknown opcodes are swallowed here
            dec_valid_o <= known;
        end else if (dec_ready_i) begin
            dec_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge c_clk) begin
        if (accept && known) begin
            dec_o <= dec_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_execute.sv
// execute stage with operand fetch and forwarding, ALU, result register and writeback stream
`timescale 1ns/1ps
`default_nettype none

module rv_execute #(
    parameter int XLEN = 64
) (
    input  wire logic                   c_clk,
    input  wire logic                   c_rst_n,
    input  wire logic                   dec_valid_i,
    input  wire rv_core_pkg::dec_t      dec_i,
    output logic                        dec_ready_o,
    output rv_core_pkg::reg_addr_t      rs1_o,
    output rv_core_pkg::reg_addr_t      rs2_o,
    input  wire logic [XLEN-1:0]        rs1_data_i,
    input  wire logic [XLEN-1:0]        rs2_data_i,
    output logic                        we_o,
    output logic                        wb_valid_o,
    output rv_core_pkg::reg_addr_t      wb_rd_o,
    output logic [XLEN-1:0]             wb_data_o,
    input  wire logic                   wb_ready_i
);

    logic            take;
    logic            fwd_a;
    logic            fwd_b;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;

    // the global stall comes only from output back-pressure
    assign dec_ready_o = !wb_valid_o || wb_ready_i;
    assign take        = dec_valid_i && dec_ready_o;

    assign rs1_o = dec_i.rs1;
    assign rs2_o = dec_i.rs2;

    // the held result is newer than the register file until it is written back
    assign fwd_a = wb_valid_o && (wb_rd_o != '0) && (wb_rd_o == dec_i.rs1);
    assign fwd_b = wb_valid_o && (wb_rd_o != '0) && (wb_rd_o == dec_i.rs2);

    assign imm_ext = XLEN'($signed(dec_i.imm));

    assign op_a = fwd_a ? wb_data_o : rs1_data_i;

    always_comb begin
        if (dec_i.use_imm) begin
            op_b = imm_ext;
        end else if (fwd_b) begin
            op_b = wb_data_o;
        end else begin
            op_b = rs2_data_i;
        end
    end

    rv_alu #(
        .XLEN     (XLEN)
    ) alu_i (
        .op_i     (dec_i.alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_res)
    );

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            wb_valid_o <= 1'b0;
        end else if (take) begin
            wb_valid_o <= 1'b1;
        end else if (wb_ready_i) begin
            wb_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge c_clk) begin
        if (take) begin
            wb_rd_o   <= dec_i.rd;
            wb_data_o <= alu_res;
        end
    end

    // register file write happens on the accepting edge
    assign we_o = wb_valid_o && wb_ready_i;

endmodule

`default_nettype wire

//--- logic/rv_regfile.sv
// integer register file with x0 tied to zero, two async reads and one sync write
`timescale 1ns/1ps
`default_nettype none

module rv_regfile #(
    parameter int XLEN = 64
) (
    input  wire logic                   c_clk,
    input  wire logic                   c_rst_n,
    input  wire rv_core_pkg::reg_addr_t rs1_i,
    input  wire rv_core_pkg::reg_addr_t rs2_i,
    output logic [XLEN-1:0]             rs1_data_o,
    output logic [XLEN-1:0]             rs2_data_o,
    input  wire logic                   we_i,
    input  wire rv_core_pkg::reg_addr_t rd_i,
    input  wire logic [XLEN-1:0]        rd_data_i
);

    logic [XLEN-1:0] regs [rv_core_pkg::REG_COUNT];

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            for (int i = 0; i < rv_core_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile and run the rv_core testbench with Verilator; exit status reflects the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_rv_core \
    --Mdir obj_dir -o tb_rv_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

//--- testbench/rv_core_chk.sv
// writeback stream assertions, attached to rv_core by the bind at the end
`timescale 1ns/1ps
`default_nettype none

module rv_core_chk #(
    parameter int XLEN = 64
) (
    input wire logic                   c_clk,
    input wire logic                   c_rst_n,
    input wire logic                   wb_valid_i,
    input wire logic                   wb_ready_i,
    input wire rv_core_pkg::reg_addr_t wb_rd_i,
    input wire logic [XLEN-1:0]        wb_data_i
);

    // a stalled result must not move
    stall_hold_a: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        (wb_valid_i && !wb_ready_i) |=> (wb_valid_i && $stable(wb_rd_i) && $stable(wb_data_i)))
        else $error("writeback valid or data changed while stalled");

    reset_idle_a: assert property (@(posedge c_clk) $rose(c_rst_n) |-> !wb_valid_i)
        else $error("writeback valid high right after reset");

    rd_known_a: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        wb_valid_i |-> !$isunknown(wb_rd_i))
        else $error("writeback rd unknown while valid");

endmodule

bind rv_core rv_core_chk #(
    .XLEN       (XLEN)
) chk_i (
    .c_clk      (c_clk),
    .c_rst_n    (c_rst_n),
    .wb_valid_i (wb_valid_o),
    .wb_ready_i (wb_ready_i),
    .wb_rd_i    (wb_rd_o),
    .wb_data_i  (wb_data_o)
);

`default_nettype wire

//--- testbench/tb_rv_core.sv
// testbench for rv_core that checks random instruction streams against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int XLEN    = 64;
    localparam int TIMEOUT = 1000;

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } wb_exp_t;

    logic            c_clk = 1'b0;
    logic            c_rst_n;
    logic            in_valid_i;
    logic [31:0]     in_instr_i;
    logic            in_ready_o;
    logic            wb_valid_o;
    logic [4:0]      wb_rd_o;
    logic [XLEN-1:0] wb_data_o;
    logic            wb_ready_i;
    logic            bp_on;
    logic [XLEN-1:0] model_regs [32];
    wb_exp_t         exp_q [$];
    int              errors;
    int              checks;
    int              base_errors;

    rv_core #(
        .XLEN       (XLEN)
    ) rv_core_i (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .in_valid_i (in_valid_i),
        .in_instr_i (in_instr_i),
        .in_ready_o (in_ready_o),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o),
        .wb_ready_i (wb_ready_i)
    );

    always #50 c_clk = ~c_clk;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // kind 0 reg-reg, 1 immediate, 2 lui
    function automatic logic [31:0] rand_op(input int kind, input logic [4:0] rs1, rs2, rd);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        f3  = 3'($urandom);
        alt = 1'($urandom);
        imm = 12'($urandom);
        if (kind == 2) return {20'($urandom), rd, 7'b0110111};
        if (kind == 0) begin
            return r_type((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
        end
        // shift immediates carry a 6-bit shamt and bit 30 picks arithmetic
        if (f3 == 3'd1) imm = {6'b0, imm[5:0]};
        else if (f3 == 3'd5) imm = {1'b0, alt, 4'b0, imm[5:0]};
        return i_type(imm, rs1, f3, rd);
    endfunction

    function automatic logic [31:0] bad_word();
        logic [6:0] opc;
        case ($urandom % 4)
            0:       opc = 7'b0000011;
            1:       opc = 7'b0100011;
            2:       opc = 7'b1100011;
            default: opc = 7'b0011011;
        endcase
        return {25'($urandom), opc};
    endfunction

    // executes one word on the model; returns 1 when a writeback is due
    function automatic logic ref_exec(input logic [31:0] w, output wb_exp_t e);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        logic [5:0]      sh;
        logic            is_imm;
        e      = '0;
        is_imm = (w[6:0] == 7'b0010011);
        if (!is_imm && w[6:0] != 7'b0110011 && w[6:0] != 7'b0110111) return 1'b0;
        a  = model_regs[w[19:15]];
        b  = is_imm ? {{52{w[31]}}, w[31:20]} : model_regs[w[24:20]];
        sh = b[5:0];
        if (w[6:0] == 7'b0110111) begin
            r = {{32{w[31]}}, w[31:12], 12'b0};
        end else begin
            case (w[14:12])
                3'd0:    r = (!is_imm && w[30]) ? a - b : a + b;
                3'd1:    r = a << sh;
                3'd2:    r = {63'b0, $signed(a) < $signed(b)};
                3'd3:    r = {63'b0, a < b};
                3'd4:    r = a ^ b;
                3'd5: begin
                    if (w[30]) begin
                        r = $signed(a) >>> sh;
                    end else begin
                        r = a >> sh;
                    end
                end
                3'd6:    r = a | b;
                default: r = a & b;
            endcase
        end
        e.rd   = w[11:7];
        e.data = r;
        if (w[11:7] != 5'd0) model_regs[w[11:7]] = r;
        return 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s", what);
        errors++;
        finish_run();
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - base_errors);
        base_errors = errors;
    endtask

    // called 10 ns after a rising edge and returns at the same point of a later cycle
    task automatic send_word(input logic [31:0] w);
        int      waited;
        wb_exp_t e;
        waited     = 0;
        in_valid_i = 1'b1;
        in_instr_i = w;
        @(negedge c_clk);
        while (!in_ready_o) begin
            if (waited == TIMEOUT) timeout_fail("input word was never accepted");
            waited++;
            @(negedge c_clk);
        end
        if (ref_exec(w, e)) exp_q.push_back(e);
        @(posedge c_clk);
        #10;
        in_valid_i = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == TIMEOUT) timeout_fail("expected writebacks never arrived");
            waited++;
            @(negedge c_clk);
        end
        @(posedge c_clk);
        #10;
    endtask

    // output sink with optional random stalls
    initial begin
        wb_ready_i = 1'b1;
        forever begin
            @(posedge c_clk);
            #10;
            wb_ready_i = bp_on ? (($urandom % 3) != 0) : 1'b1;
        end
    end

    // comparator samples mid-cycle ahead of the accepting edge
    initial begin
        wb_exp_t e;
        forever begin
            @(negedge c_clk);
            if (c_rst_n && wb_valid_o && wb_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected writeback to x%0d with nothing pending", wb_rd_o);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_value("wb_rd_o", 64'(wb_rd_o), 64'(e.rd));
                    check_value("wb_data_o", wb_data_o, e.data);
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hbfa30086));
        c_rst_n     = 1'b0;
        in_valid_i  = 1'b0;
        in_instr_i  = '0;
        bp_on       = 1'b0;
        errors      = 0;
        checks      = 0;
        base_errors = 0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        repeat (16) @(posedge c_clk);
        #10;
        c_rst_n = 1'b1;
        @(negedge c_clk);
        check_value("wb_valid_o", 64'(wb_valid_o), 64'd0);
        check_value("in_ready_o", 64'(in_ready_o), 64'd1);
        end_test(1, "reset state");
        @(posedge c_clk);
        #10;

        for (int r = 1; r < 32; r++) begin
            send_word(rand_op(2, 5'd0, 5'd0, 5'(r)));
            send_word(i_type(12'($urandom), 5'(r), 3'd0, 5'(r)));
        end
        repeat (200) send_word(rand_op(0, 5'($urandom), 5'($urandom), 5'($urandom_range(31, 1))));
        drain();
        end_test(2, "reg-reg operations");

        repeat (150) send_word(rand_op(($urandom % 4 == 0) ? 2 : 1, 5'($urandom), 5'd0,
                                       5'($urandom)));
        send_word(i_type(12'h7ff, 5'd9, 3'd0, 5'd0));
        send_word(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd10));
        send_word(i_type(12'hfff, 5'd0, 3'd6, 5'd11));
        drain();
        end_test(3, "immediates, lui and x0");

        begin
            logic [4:0] prev;
            logic [4:0] rd;
            prev = 5'($urandom_range(31, 1));
            repeat (100) begin
                rd = 5'($urandom_range(31, 1));
                send_word(rand_op(int'($urandom % 2), prev, ($urandom % 2) ? prev : 5'($urandom),
                                  rd));
                prev = rd;
            end
        end
        drain();
        end_test(4, "dependent chains");

        bp_on = 1'b1;
        repeat (300) send_word(rand_op(int'($urandom % 3), 5'($urandom), 5'($urandom),
                                       5'($urandom)));
        drain();
        bp_on = 1'b0;
        end_test(5, "output back-pressure");

        repeat (40) begin
            send_word(bad_word());
            if ($urandom % 2 == 0) send_word(rand_op(1, 5'($urandom), 5'd0, 5'($urandom)));
        end
        // read every register back through or with x0
        for (int r = 1; r < 32; r++) send_word(r_type(7'h00, 5'd0, 5'(r), 3'd6, 5'(r)));
        drain();
        end_test(6, "unsupported opcodes");

        repeat (4) @(posedge c_clk);
        finish_run();
    end

endmodule

`default_nettype wire
